// ==== design/vec_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the vector coprocessor
// Elements are 32 bit and there are 8 vector registers
// No masking, no floating point, no fixed point
// The vl field of an instruction is an element count
//////////////////////////////////////////////////

`default_nettype none

package vec_pkg;

  // Element width in bits
  localparam int unsigned ELEN = 32;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 8;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;
  typedef logic [ELEN-1:0] elem_t;
  // Vector length, counted in elements
  typedef logic [31:0] vlen_t;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_SETVL   = 4'd0,
    OP_VID     = 4'd1,
    OP_VMV_VX  = 4'd2,
    OP_VADD_VV = 4'd3,
    OP_VSUB_VV = 4'd4,
    OP_VAND_VV = 4'd5,
    OP_VOR_VV  = 4'd6,
    OP_VXOR_VV = 4'd7,
    OP_VADD_VX = 4'd8,
    OP_VEXT_XV = 4'd9
  } vec_op_e;

  //////////////////////////////////////////////////
  // Request and response formats
  //////////////////////////////////////////////////

  // Request from the scalar core
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } acc_req_t;

  // New vl for OP_SETVL, element for OP_VEXT_XV, zero otherwise
  typedef struct packed {
    elem_t result;
  } acc_resp_t;

  // Instruction as seen by the sequencer and the lanes
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vlen_t     vl;
  } pe_req_t;

endpackage : vec_pkg

`default_nettype wire

// ==== design/vec_dispatcher.sv ====
//////////////////////////////////////////////////
// Core-facing front end of the coprocessor
// Accepts one request at a time, owns vl
// OP_SETVL is answered here, one cycle after acceptance
// Holds the response until the core takes it
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher import vec_pkg::*; #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  // Scalar core side
  input  wire acc_req_t  acc_req_i,
  input  wire logic      acc_req_valid_i,
  output logic           acc_req_ready_o,
  output acc_resp_t      acc_resp_o,
  output logic           acc_resp_valid_o,
  input  wire logic      acc_resp_ready_i,
  // Sequencer side
  output pe_req_t        ara_req_o,
  output logic           ara_req_valid_o,
  input  wire elem_t     ara_resp_i,
  input  wire logic      ara_resp_valid_i
);

  localparam int unsigned VLMAX = NrLanes * ElemsPerLane;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    RESP
  } disp_state_e;

  disp_state_e state_q;
  vlen_t       vl_q;
  vlen_t       vl_clamped;
  acc_resp_t   resp_q;
  pe_req_t     ara_req_q;
  logic        ara_req_valid_q;

  // min(scalar, VLMAX)
  assign vl_clamped = (acc_req_i.scalar > 32'(VLMAX)) ? 32'(VLMAX) : acc_req_i.scalar;

  assign acc_req_ready_o  = (state_q == IDLE);
  assign acc_resp_valid_o = (state_q == RESP);
  assign acc_resp_o       = resp_q;
  assign ara_req_o        = ara_req_q;
  assign ara_req_valid_o  = ara_req_valid_q;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q         <= IDLE;
      vl_q            <= '0;
      ara_req_valid_q <= 1'b0;
    end else begin
      ara_req_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (acc_req_valid_i) begin
            if (acc_req_i.op == OP_SETVL) begin
              vl_q    <= vl_clamped;
              state_q <= RESP;
            end else begin
              ara_req_valid_q <= 1'b1;
              state_q         <= BUSY;
            end
          end
        end
        BUSY: begin
          if (ara_resp_valid_i) state_q <= RESP;
        end
        RESP: begin
          if (acc_resp_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload, only meaningful under the matching valid
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && acc_req_valid_i) begin
      resp_q.result <= vl_clamped;
      ara_req_q     <= '{op: acc_req_i.op, vd: acc_req_i.vd, vs1: acc_req_i.vs1,
                         vs2: acc_req_i.vs2, scalar: acc_req_i.scalar, vl: vl_q};
    end else if (state_q == BUSY && ara_resp_valid_i) begin
      resp_q.result <= ara_resp_i;
    end
  end

endmodule : vec_dispatcher

`default_nettype wire

// ==== design/vec_sequencer.sv ====
//////////////////////////////////////////////////
// Broadcasts one instruction to all lanes
// Waits for a done pulse from every lane
// Only one instruction may be in flight
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_sequencer import vec_pkg::*; #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  // Dispatcher side
  input  wire pe_req_t               ara_req_i,
  input  wire logic                  ara_req_valid_i,
  output elem_t                      ara_resp_o,
  output logic                       ara_resp_valid_o,
  // Lane side
  output pe_req_t                    pe_req_o,
  output logic                       pe_req_valid_o,
  input  wire logic  [NrLanes-1:0]   lane_done_i,
  input  wire elem_t [NrLanes-1:0]   lane_elem_i
);

  localparam int unsigned VLMAX = NrLanes * ElemsPerLane;
  localparam int unsigned LaneW = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  pe_req_t            pe_req_q;
  logic               pe_req_valid_q;
  logic [NrLanes-1:0] pending_q;
  logic [NrLanes-1:0] pending_left;
  logic               all_done;
  elem_t              ara_resp_q;
  logic               ara_resp_valid_q;
  logic [31:0]        ext_idx;
  logic [LaneW-1:0]   ext_lane;

  assign pe_req_o         = pe_req_q;
  assign pe_req_valid_o   = pe_req_valid_q;
  assign ara_resp_o       = ara_resp_q;
  assign ara_resp_valid_o = ara_resp_valid_q;

  // Lanes still running after this cycle's done pulses
  assign pending_left = pending_q & ~lane_done_i;
  assign all_done     = (pending_q != '0) && (pending_left == '0);

  // Element i sits in lane i mod NrLanes
  assign ext_idx  = pe_req_q.scalar % 32'(VLMAX);
  assign ext_lane = LaneW'(ext_idx % 32'(NrLanes));

  //////////////////////////////////////////////////
  // Broadcast and completion tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pe_req_valid_q   <= 1'b0;
      pending_q        <= '0;
      ara_resp_valid_q <= 1'b0;
    end else begin
      pe_req_valid_q   <= ara_req_valid_i;
      ara_resp_valid_q <= all_done;
      if (ara_req_valid_i) begin
        pending_q <= '1;
      end else begin
        pending_q <= pending_left;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ara_req_valid_i) pe_req_q <= ara_req_i;
    if (all_done) begin
      ara_resp_q <= (pe_req_q.op == OP_VEXT_XV) ? lane_elem_i[ext_lane] : '0;
    end
  end

endmodule : vec_sequencer

`default_nettype wire

// ==== design/vec_lane.sv ====
//////////////////////////////////////////////////
// One vector lane
// Holds elements LaneId, LaneId+NrLanes, ... of each register
// One row per cycle, elements at or above vl are left alone
// Register contents are undefined after reset
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4,
  parameter int unsigned LaneId       = 0
) (
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  input  wire pe_req_t pe_req_i,
  input  wire logic    pe_req_valid_i,
  output logic         lane_done_o,
  output elem_t        lane_elem_o
);

  localparam int unsigned VLMAX = NrLanes * ElemsPerLane;
  localparam int unsigned RowW  = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  // Register file slice
  elem_t vrf_q [NrVRegs][ElemsPerLane];

  pe_req_t         req_q;
  logic            active_q;
  logic            done_q;
  logic [RowW-1:0] row_q;
  logic [RowW-1:0] last_row;
  logic [31:0]     nr_rows;
  logic [31:0]     elem_idx;
  logic [31:0]     ext_idx;
  logic [RowW-1:0] ext_row;
  elem_t           elem_a;
  elem_t           elem_b;
  elem_t           result;
  logic            wr_en;

  // Rows to walk, at least one even for vl == 0
  always_comb begin
    nr_rows = (req_q.vl + 32'(NrLanes) - 32'd1) / 32'(NrLanes);
    if (req_q.op == OP_VEXT_XV || nr_rows == '0) begin
      last_row = '0;
    end else begin
      last_row = RowW'(nr_rows - 32'd1);
    end
  end

  assign elem_idx = 32'(row_q) * 32'(NrLanes) + 32'(LaneId);

  //////////////////////////////////////////////////
  // Element ALU
  //////////////////////////////////////////////////

  // First input is vs2, second input vs1 or the scalar
  always_comb begin
    elem_a = vrf_q[req_q.vs2][row_q];
    elem_b = vrf_q[req_q.vs1][row_q];
    case (req_q.op)
      OP_VID:     result = elem_idx;
      OP_VMV_VX:  result = req_q.scalar;
      OP_VADD_VV: result = elem_a + elem_b;
      OP_VSUB_VV: result = elem_a - elem_b;
      OP_VAND_VV: result = elem_a & elem_b;
      OP_VOR_VV:  result = elem_a | elem_b;
      OP_VXOR_VV: result = elem_a ^ elem_b;
      OP_VADD_VX: result = elem_a + req_q.scalar;
      default:    result = '0;
    endcase
  end

  assign wr_en = active_q && (req_q.op != OP_VEXT_XV) && (elem_idx < req_q.vl);

  // Extract reads vs2, independent of vl
  assign ext_idx     = req_q.scalar % 32'(VLMAX);
  assign ext_row     = RowW'(ext_idx / 32'(NrLanes));
  assign lane_elem_o = vrf_q[req_q.vs2][ext_row];
  assign lane_done_o = done_q;

  //////////////////////////////////////////////////
  // Row sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      row_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (pe_req_valid_i) begin
        active_q <= 1'b1;
        row_q    <= '0;
      end else if (active_q) begin
        if (row_q == last_row) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) req_q <= pe_req_i;
    if (wr_en) vrf_q[req_q.vd][row_q] <= result;
  end

endmodule : vec_lane

`default_nettype wire

// ==== design/vec_top.sv ====
//////////////////////////////////////////////////
// Vector coprocessor top level
// NrLanes and ElemsPerLane must be powers of two
// VLMAX is NrLanes * ElemsPerLane
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_top import vec_pkg::*; #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire acc_req_t  acc_req_i,
  input  wire logic      acc_req_valid_i,
  output logic           acc_req_ready_o,
  output acc_resp_t      acc_resp_o,
  output logic           acc_resp_valid_o,
  input  wire logic      acc_resp_ready_i
);

  // Dispatcher to sequencer
  pe_req_t ara_req;
  logic    ara_req_valid;
  elem_t   ara_resp;
  logic    ara_resp_valid;

  // Sequencer to lanes
  pe_req_t                   pe_req;
  logic                      pe_req_valid;
  logic         [NrLanes-1:0] lane_done;
  elem_t        [NrLanes-1:0] lane_elem;

  vec_dispatcher #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) i_dispatcher (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i),
    .ara_req_o       (ara_req         ),
    .ara_req_valid_o (ara_req_valid   ),
    .ara_resp_i      (ara_resp        ),
    .ara_resp_valid_i(ara_resp_valid  )
  );

  vec_sequencer #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) i_sequencer (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .ara_req_i       (ara_req       ),
    .ara_req_valid_i (ara_req_valid ),
    .ara_resp_o      (ara_resp      ),
    .ara_resp_valid_o(ara_resp_valid),
    .pe_req_o        (pe_req        ),
    .pe_req_valid_o  (pe_req_valid  ),
    .lane_done_i     (lane_done     ),
    .lane_elem_i     (lane_elem     )
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar g = 0; g < NrLanes; g++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane),
      .LaneId      (g           )
    ) i_lane (
      .clk_i         (clk_i       ),
      .rst_n_i       (rst_n_i     ),
      .pe_req_i      (pe_req      ),
      .pe_req_valid_i(pe_req_valid),
      .lane_done_o   (lane_done[g]),
      .lane_elem_o   (lane_elem[g])
    );
  end : gen_lanes

  // Elaboration checks
  if (NrLanes == 0 || (NrLanes & (NrLanes - 1)) != 0) begin : gen_bad_lanes
    $error("[vec_top] NrLanes must be a nonzero power of two");
  end

  if (ElemsPerLane == 0 || (ElemsPerLane & (ElemsPerLane - 1)) != 0) begin : gen_bad_elems
    $error("[vec_top] ElemsPerLane must be a nonzero power of two");
  end

endmodule : vec_top

`default_nettype wire

// ==== verif/tb_vec_ref.svh ====
//////////////////////////////////////////////////
// Reference model of vl and the vector registers
// Included inside the testbench module body
// Needs VLMAX declared before the include
//////////////////////////////////////////////////

`ifndef TB_VEC_REF_SVH
`define TB_VEC_REF_SVH

elem_t       model_vrf [NrVRegs][VLMAX];
logic [31:0] model_vl;

// Expected response of one request, model updated in place
function automatic logic [31:0] ref_step(input acc_req_t req);
  logic [31:0] res;
  elem_t       a;
  elem_t       b;
  int unsigned i;
  res = '0;
  case (req.op)
    OP_SETVL: begin
      model_vl = (req.scalar > VLMAX) ? VLMAX : req.scalar;
      res      = model_vl;
    end
    // Read regardless of vl
    OP_VEXT_XV: res = model_vrf[req.vs2][req.scalar % VLMAX];
    default: begin
      for (i = 0; i < model_vl; i++) begin
        a = model_vrf[req.vs2][i];
        b = model_vrf[req.vs1][i];
        case (req.op)
          OP_VID:     model_vrf[req.vd][i] = i;
          OP_VMV_VX:  model_vrf[req.vd][i] = req.scalar;
          OP_VADD_VV: model_vrf[req.vd][i] = a + b;
          OP_VSUB_VV: model_vrf[req.vd][i] = a - b;
          OP_VAND_VV: model_vrf[req.vd][i] = a & b;
          OP_VOR_VV:  model_vrf[req.vd][i] = a | b;
          OP_VXOR_VV: model_vrf[req.vd][i] = a ^ b;
          OP_VADD_VX: model_vrf[req.vd][i] = a + req.scalar;
          default:    model_vrf[req.vd][i] = model_vrf[req.vd][i];
        endcase
      end
    end
  endcase
  return res;
endfunction

`endif

// ==== verif/tb_vec_top.sv ====
//////////////////////////////////////////////////
// Testbench of the vector coprocessor
// One request at a time
// Responses checked in order
// Default build of 4 lanes with 4 elements each
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned VLMAX        = NrLanes * ElemsPerLane;
  localparam int unsigned ReqTimeout   = 100;
  localparam int unsigned RespTimeout  = 200;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  acc_req_t    acc_req_i;
  logic        acc_req_valid_i;
  logic        acc_req_ready_o;
  acc_resp_t   acc_resp_o;
  logic        acc_resp_valid_o;
  logic        acc_resp_ready_i = 1'b1;

  integer      seed = 32'h9f0d;
  logic [31:0] exp_q [$];
  int unsigned sent_cnt = 0;
  int unsigned recv_cnt = 0;
  logic        bp_en = 1'b0;
  int unsigned stall_left = 0;
  logic        held_q = 1'b0;
  logic [31:0] held_val = '0;

  `include "tb_vec_ref.svh"

  vec_top #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) i_dut (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  //////////////////////////////////////////////////
  // Request driver
  //////////////////////////////////////////////////

  // Issue one request and wait until its response is taken
  task automatic send_req(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                          input vreg_idx_t vs2, input logic [31:0] scalar);
    acc_req_t    req;
    int unsigned waited;
    req = '{op: op, vd: vd, vs1: vs1, vs2: vs2, scalar: scalar};
    exp_q.push_back(ref_step(req));
    sent_cnt++;
    acc_req_i       <= req;
    acc_req_valid_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > ReqTimeout) fail_now("Timeout waiting for acc_req_ready_o");
    end while (!acc_req_ready_o);
    acc_req_valid_i <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > RespTimeout) fail_now("Timeout waiting for the response handshake");
    end while (!(acc_resp_valid_o && acc_resp_ready_i));
  endtask

  task automatic set_vl(input logic [31:0] n);
    send_req(OP_SETVL, 0, 0, 0, n);
  endtask

  // Extract every element with indices that sometimes wrap past VLMAX
  task automatic read_all(input vreg_idx_t vreg);
    int unsigned i;
    for (i = 0; i < VLMAX; i++) begin
      send_req(OP_VEXT_XV, 0, 0, vreg, i + VLMAX * ($unsigned($random(seed)) % 4));
    end
  endtask

  task automatic fill_regs(input int unsigned vid_reg);
    int unsigned r;
    for (r = 0; r < NrVRegs; r++) begin
      if (r == vid_reg) send_req(OP_VID, vreg_idx_t'(r), 0, 0, 0);
      else send_req(OP_VMV_VX, vreg_idx_t'(r), 0, 0, $random(seed));
    end
  endtask

  task automatic random_rounds(input int unsigned rounds);
    int unsigned rnd;
    int unsigned k;
    int unsigned r;
    vec_op_e     op;
    for (rnd = 0; rnd < rounds; rnd++) begin
      set_vl($unsigned($random(seed)) % (VLMAX + 5));
      fill_regs(rnd % NrVRegs);
      for (k = 0; k < 12; k++) begin
        case ($unsigned($random(seed)) % 6)
          0:       op = OP_VADD_VV;
          1:       op = OP_VSUB_VV;
          2:       op = OP_VAND_VV;
          3:       op = OP_VOR_VV;
          4:       op = OP_VXOR_VV;
          default: op = OP_VADD_VX;
        endcase
        send_req(op, vreg_idx_t'($random(seed)), vreg_idx_t'($random(seed)),
                 vreg_idx_t'($random(seed)), $random(seed));
      end
      for (r = 0; r < NrVRegs; r++) read_all(vreg_idx_t'(r));
    end
  endtask

  //////////////////////////////////////////////////
  // Response ready with random stalls
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!bp_en) begin
      acc_resp_ready_i <= 1'b1;
    end else if (stall_left != 0) begin
      acc_resp_ready_i <= 1'b0;
      stall_left       <= stall_left - 1;
    end else begin
      acc_resp_ready_i <= 1'b1;
      if (($random(seed) & 3) == 0) stall_left <= 1 + $unsigned($random(seed)) % 6;
    end
  end

  // Responses checked in order against the model
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (acc_resp_valid_o) begin
        check_val("acc_req_ready_o", 32'(acc_req_ready_o), 32'd0);
        if (held_q) check_val("acc_resp_o", acc_resp_o.result, held_val);
        held_q   = !acc_resp_ready_i;
        held_val = acc_resp_o.result;
        if (acc_resp_ready_i) begin
          if (exp_q.size() == 0) fail_now("Response arrived with no request outstanding");
          check_val("acc_resp_o", acc_resp_o.result, exp_q.pop_front());
          recv_cnt <= recv_cnt + 1;
        end
      end else if (held_q) begin
        fail_now("acc_resp_valid_o dropped before the response was taken");
      end
    end
  end

  initial begin
    rst_n_i         = 1'b0;
    acc_req_i       = '0;
    acc_req_valid_i = 1'b0;
    model_vl        = '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_val("acc_resp_valid_o", 32'(acc_resp_valid_o), 32'd0);
    check_val("acc_req_ready_o", 32'(acc_req_ready_o), 32'd1);
    // vl is still 0 here
    send_req(OP_VID, 3, 0, 0, 0);
    set_vl(VLMAX);
    fill_regs(NrVRegs);
    set_vl(0);
    send_req(OP_VID, 3, 0, 0, 0);
    read_all(3);
    // Clamp at VLMAX
    set_vl(0);
    set_vl(5);
    set_vl(16);
    set_vl(40);
    // Full length vid over every lane and row
    set_vl(VLMAX);
    send_req(OP_VID, 2, 0, 0, 0);
    read_all(2);
    random_rounds(6);
    bp_en <= 1'b1;
    random_rounds(4);
    bp_en <= 1'b0;
    @(posedge clk_i);
    if (sent_cnt == recv_cnt && exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Sent %0d requests but got %0d responses", sent_cnt, recv_cnt);
      $display("TB FAILED");
      $fatal(1, "response count mismatch");
    end
  end

endmodule : tb_vec_top

`default_nettype wire

// ==== list.f ====
+incdir+verif
design/vec_pkg.sv
design/vec_dispatcher.sv
design/vec_sequencer.sv
design/vec_lane.sv
design/vec_top.sv
verif/tb_vec_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and scan the simulation log for a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_vec_top \
  -Mdir obj_dir -o tb_vec_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_vec_top > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
